//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

//--- alu/exec_alu.sv
`timescale 1ns/1ps

module exec_alu import issue_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue_valid,
  input  opcode_t           issue_op,
  input  cond_t             issue_cond,
  input  logic [REG_W-1:0]  issue_rd,
  input  logic [DATA_W-1:0] issue_a,
  input  logic [DATA_W-1:0] issue_b,
  input  flags_t            issue_flags,
  output logic              wb_valid,
  output logic [REG_W-1:0]  wb_rd,
  output logic [DATA_W-1:0] wb_data,
  output logic              wb_write,
  output logic              wb_flags_valid,
  output flags_t            wb_flags
);

  logic              cond_ok;
  logic              sub;
  logic [DATA_W-1:0] b_op;
  logic [DATA_W:0]   sum;
  logic [4:0]        shamt;
  logic [DATA_W-1:0] result;
  flags_t            cmp_flags;

  logic              s1_valid;
  logic              s1_write;
  logic              s1_flags_valid;
  logic [REG_W-1:0]  s1_rd;
  logic [DATA_W-1:0] s1_data;
  flags_t            s1_flags;

  assign cond_ok = cond_true(issue_cond, issue_flags);

  // a + ~b + 1 for sub and cmp, carry out is the c flag
  assign sub   = issue_op == OP_SUB || issue_op == OP_CMP;
  assign b_op  = sub ? ~issue_b : issue_b;
  assign sum   = {1'b0, issue_a} + {1'b0, b_op} + {{DATA_W{1'b0}}, sub};
  assign shamt = issue_b[4:0];

  always_comb begin
    case (issue_op)
      OP_AND:  result = issue_a & issue_b;
      OP_OR:   result = issue_a | issue_b;
      OP_XOR:  result = issue_a ^ issue_b;
      OP_SHL:  result = issue_a << shamt;
      OP_SHR:  result = issue_a >> shamt;
      OP_SAR:  result = $signed(issue_a) >>> shamt;
      OP_LDI:  result = issue_b;
      default: result = sum[DATA_W-1:0];
    endcase
  end

  always_comb begin
    cmp_flags.z = ~|sum[DATA_W-1:0];
    cmp_flags.n = sum[DATA_W-1];
    cmp_flags.c = sum[DATA_W];
    cmp_flags.v = (issue_a[DATA_W-1] ^ issue_b[DATA_W-1])
                & (sum[DATA_W-1] ^ issue_a[DATA_W-1]);
  end

  // stage 1
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid       <= 1'b0;
      s1_write       <= 1'b0;
      s1_flags_valid <= 1'b0;
    end else begin
      s1_valid       <= issue_valid;
      s1_write       <= issue_valid && cond_ok && issue_op != OP_CMP;
      s1_flags_valid <= issue_valid && cond_ok && issue_op == OP_CMP;
    end
  end

  always_ff @(posedge clk) begin
    s1_rd    <= issue_rd;
    s1_data  <= result;
    s1_flags <= cmp_flags;
  end

  // stage 2, broadcast
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid       <= 1'b0;
      wb_write       <= 1'b0;
      wb_flags_valid <= 1'b0;
    end else begin
      wb_valid       <= s1_valid;
      wb_write       <= s1_write;
      wb_flags_valid <= s1_flags_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd    <= s1_rd;
    wb_data  <= s1_data;
    wb_flags <= s1_flags;
  end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // held over the first rising edges, released just after one
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- bench/result_check.sv
`timescale 1ns/1ps

module result_check import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  input  logic        pready,
  input  logic [31:0] prdata,
  input  logic        pslverr,
  output int          value_errors
);

  // in-order ISA state, flags kept as {z, n, c, v}
  logic [31:0] model_regs [NUM_REGS];
  logic [3:0]  model_flags;
  int          inserts;
  int          errs = 0;

  assign value_errors = errs;

  function automatic logic op_defined(logic [3:0] code);
    case (code)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SAR,
      OP_ADDI, OP_LDI, OP_CMP: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic cond_defined(logic [3:0] code);
    case (code)
      COND_AL, COND_EQ, COND_NE, COND_LT, COND_GE,
      COND_LTU, COND_GEU, COND_GT, COND_LE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic cond_holds(logic [3:0] code, logic [3:0] f);
    logic z;
    logic n;
    logic c;
    logic v;
    logic res;
    z = f[3];
    n = f[2];
    c = f[1];
    v = f[0];
    case (code)
      COND_AL:  res = 1'b1;
      COND_EQ:  res = z;
      COND_NE:  res = !z;
      COND_LT:  res = n != v;
      COND_GE:  res = n == v;
      COND_LTU: res = !c;
      COND_GEU: res = c;
      COND_GT:  res = !z && n == v;
      COND_LE:  res = z || n != v;
      default:  res = 1'b0;
    endcase
    return res;
  endfunction

  function automatic logic reg_addr(logic [11:0] addr);
    return addr >= ADDR_REG_BASE && addr <= ADDR_REG_BASE + 12'h03c && addr[1:0] == 2'b00;
  endfunction

  function automatic logic access_ok(logic wr, logic [11:0] addr, logic [31:0] data);
    if (wr) begin
      return addr == ADDR_INSN && op_defined(data[31:28]) && cond_defined(data[27:24]);
    end
    return reg_addr(addr) || addr == ADDR_FLAGS || addr == ADDR_STATUS;
  endfunction

  task automatic apply_insn(input logic [31:0] w);
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [32:0] diff;
    op  = w[31:28];
    a   = model_regs[w[19:16]];
    b   = model_regs[w[15:12]];
    imm = {{20{w[11]}}, w[11:0]};
    res = 32'h0;
    inserts++;
    if (cond_holds(w[27:24], model_flags)) begin
      case (op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_SHL:  res = a << b[4:0];
        OP_SHR:  res = a >> b[4:0];
        OP_SAR:  res = $signed(a) >>> b[4:0];
        OP_ADDI: res = a + imm;
        OP_LDI:  res = imm;
        default: res = 32'h0;
      endcase
      if (op == OP_CMP) begin
        // carry out of a + ~b + 1
        diff = {1'b0, a} + {1'b0, ~b} + 33'd1;
        model_flags = {diff[31:0] == 32'h0, diff[31], diff[32],
                       a[31] != b[31] && diff[31] != a[31]};
      end else begin
        model_regs[w[23:20]] = res;
      end
    end
  endtask

  task automatic check_completion();
    logic        ok;
    logic [31:0] expected;
    ok = access_ok(pwrite, paddr, pwdata);
    if (pslverr !== !ok) begin
      errs++;
      $display("[ERROR] pslverr at 0x%03h: expected 0x%0h, got 0x%0h", paddr, !ok, pslverr);
    end
    if (ok && pwrite) begin
      apply_insn(pwdata);
    end else if (ok && paddr == ADDR_STATUS) begin
      if (prdata > QUEUE_DEPTH || (inserts == 0 && prdata != 32'h0)) begin
        errs++;
        $display("[ERROR] prdata status: expected at most 0x%0h, got 0x%08h",
                 inserts == 0 ? 0 : QUEUE_DEPTH, prdata);
      end
    end else if (ok) begin
      expected = paddr == ADDR_FLAGS ? {28'h0, model_flags} : model_regs[paddr[5:2]];
      if (prdata !== expected) begin
        errs++;
        $display("[ERROR] prdata at 0x%03h: expected 0x%08h, got 0x%08h",
                 paddr, expected, prdata);
      end
    end
  endtask

  // half a period away from the edges where the bus and the DUT move
  always @(negedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        model_regs[r] = 32'h0;
      end
      model_flags = 4'h0;
      inserts     = 0;
    end else if (psel && penable && pready) begin
      check_completion();
    end
  end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
);

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 8;
  localparam int XFER_LIMIT   = 40;
  localparam int N_BURST      = 64;
  localparam int N_ROUNDS     = 6;
  localparam int N_COND       = 8;
  localparam int N_CHAIN      = 15;

  // transfers per test, in the order they run
  localparam int N_TRANS = (NUM_REGS + 2)
                         + (N_BURST + NUM_REGS)
                         + (N_ROUNDS * (N_COND + 2) + NUM_REGS + 1)
                         + (8 + NUM_REGS + 1)
                         + (2 * N_CHAIN + NUM_REGS + 1);
  localparam int WATCHDOG_CYCLES = N_TRANS * 40 + RESET_CYCLES;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;

  logic [31:0] rng = 32'h4f5c;
  int          other_errors = 0;
  int          value_errors;

  clk_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (.clk, .rst);

  issue_slice_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) UUT (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .pready, .prdata, .pslverr
  );

  result_check #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_check (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .pready, .prdata, .pslverr,
    .value_errors
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [31:0] make_insn(logic [3:0] op, logic [3:0] cd, logic [3:0] rd,
                                            logic [3:0] ra, logic [3:0] rb, logic [11:0] imm);
    return {op, cd, rd, ra, rb, imm};
  endfunction

  function automatic logic [3:0] alu_op(int k);
    case (k)
      0:       return OP_ADD;
      1:       return OP_SUB;
      2:       return OP_AND;
      3:       return OP_OR;
      4:       return OP_XOR;
      5:       return OP_SHL;
      6:       return OP_SHR;
      7:       return OP_SAR;
      8:       return OP_ADDI;
      default: return OP_LDI;
    endcase
  endfunction

  function automatic logic [3:0] any_op(int k);
    return k < 10 ? alu_op(k) : OP_CMP;
  endfunction

  function automatic logic [3:0] cond_at(int k);
    case (k)
      0:       return COND_AL;
      1:       return COND_EQ;
      2:       return COND_NE;
      3:       return COND_LT;
      4:       return COND_GE;
      5:       return COND_LTU;
      6:       return COND_GEU;
      7:       return COND_GT;
      default: return COND_LE;
    endcase
  endfunction

  function automatic logic [3:0] chain_op(int k);
    case (k % 4)
      0:       return OP_ADD;
      1:       return OP_SHL;
      2:       return OP_ADDI;
      default: return OP_SUB;
    endcase
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready && waited < XFER_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!pready) begin
      other_errors++;
      $display("APB %s at 0x%03h got no pready within %0d cycles",
               wr ? "write" : "read", addr, XFER_LIMIT);
    end
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_insn(input logic [31:0] w);
    apb_xfer(1'b1, ADDR_INSN, w);
  endtask

  task automatic read_reg(input logic [3:0] r);
    apb_xfer(1'b0, ADDR_REG_BASE | {6'b0, r, 2'b00}, 32'h0);
  endtask

  task automatic read_all_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      read_reg(4'(r));
    end
  endtask

  task automatic read_flags();
    apb_xfer(1'b0, ADDR_FLAGS, 32'h0);
  endtask

  task automatic read_status();
    apb_xfer(1'b0, ADDR_STATUS, 32'h0);
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] v;
    logic [3:0]  ra;
    logic [3:0]  rb;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 12'h0;
    pwdata  = 32'h0;
    repeat (RESET_CYCLES + 1) @(posedge clk);
    #1;

    // reset state
    read_all_regs();
    read_flags();
    read_status();

    // dense dependencies on r0..r7
    for (int i = 0; i < N_BURST; i++) begin
      w = rand_word();
      v = rand_word();
      if (i < 8) begin
        write_insn(make_insn(OP_LDI, COND_AL, 4'(i), w[3:0], w[7:4], v[11:0]));
      end else begin
        write_insn(make_insn(alu_op(int'(w % 10)), COND_AL, {1'b0, v[14:12]},
                             {1'b0, v[18:16]}, {1'b0, v[22:20]}, v[11:0]));
      end
    end
    read_all_regs();

    // conditions against fresh flags, every third compare of a register with itself
    for (int r = 0; r < N_ROUNDS; r++) begin
      w  = rand_word();
      ra = w[3:0];
      rb = (r % 3 == 0) ? ra : w[7:4];
      write_insn(make_insn(OP_CMP, COND_AL, 4'h0, ra, rb, 12'h0));
      read_flags();
      for (int k = 0; k < N_COND; k++) begin
        w = rand_word();
        v = rand_word();
        write_insn(make_insn(any_op(int'(w % 11)), cond_at((r * N_COND + k) % 9),
                             v[15:12], v[19:16], v[23:20], v[11:0]));
      end
    end
    read_all_regs();
    read_flags();

    // error responses, none of them may touch state
    write_insn(make_insn(4'hc, COND_AL, 4'h1, 4'h2, 4'h3, 12'h0));
    write_insn(make_insn(OP_ADD, 4'hd, 4'h1, 4'h2, 4'h3, 12'h0));
    apb_xfer(1'b0, 12'h100, 32'h0);
    apb_xfer(1'b1, 12'h104, make_insn(OP_LDI, COND_AL, 4'h1, 4'h0, 4'h0, 12'h5a5));
    apb_xfer(1'b1, ADDR_REG_BASE | 12'h004, make_insn(OP_LDI, COND_AL, 4'h1, 4'h0, 4'h0, 12'h5a5));
    apb_xfer(1'b1, ADDR_FLAGS, 32'h0);
    apb_xfer(1'b0, ADDR_INSN, 32'h0);
    apb_xfer(1'b0, ADDR_REG_BASE | 12'h002, 32'h0);
    read_all_regs();
    read_flags();

    // chain through r1..r15, occupancy sampled after every insert
    write_insn(make_insn(OP_LDI, COND_AL, 4'h1, 4'h0, 4'h0, 12'h003));
    read_status();
    for (int i = 2; i <= N_CHAIN; i++) begin
      write_insn(make_insn(chain_op(i), COND_AL, 4'(i), 4'(i - 1), 4'h1, 12'h7f3));
      read_status();
    end
    read_all_regs();
    read_status();

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- common/issue_pkg.sv
package issue_pkg;

  localparam int DATA_W   = 32;
  localparam int NUM_REGS = 16;
  localparam int REG_W    = 4;

  // instruction word layout
  localparam int OPC_LSB  = 28;
  localparam int COND_LSB = 24;
  localparam int RD_LSB   = 20;
  localparam int RA_LSB   = 16;
  localparam int RB_LSB   = 12;
  localparam int IMM_W    = 12;

  // apb map
  localparam logic [11:0] ADDR_INSN     = 12'h000;
  localparam logic [11:0] ADDR_REG_BASE = 12'h040;
  localparam logic [11:0] ADDR_FLAGS    = 12'h080;
  localparam logic [11:0] ADDR_STATUS   = 12'h084;

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_SAR  = 4'd7,
    OP_ADDI = 4'd8,
    OP_LDI  = 4'd9,
    OP_CMP  = 4'd10
  } opcode_t;

  typedef enum logic [3:0] {
    COND_AL  = 4'd0,
    COND_EQ  = 4'd1,
    COND_NE  = 4'd2,
    COND_LT  = 4'd3,
    COND_GE  = 4'd4,
    COND_LTU = 4'd5,
    COND_GEU = 4'd6,
    COND_GT  = 4'd7,
    COND_LE  = 4'd8
  } cond_t;

  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

  function automatic opcode_t insn_opcode(logic [31:0] insn);
    return opcode_t'(insn[OPC_LSB +: 4]);
  endfunction

  function automatic cond_t insn_cond(logic [31:0] insn);
    return cond_t'(insn[COND_LSB +: 4]);
  endfunction

  function automatic logic [REG_W-1:0] insn_rd(logic [31:0] insn);
    return insn[RD_LSB +: REG_W];
  endfunction

  function automatic logic [REG_W-1:0] insn_ra(logic [31:0] insn);
    return insn[RA_LSB +: REG_W];
  endfunction

  function automatic logic [REG_W-1:0] insn_rb(logic [31:0] insn);
    return insn[RB_LSB +: REG_W];
  endfunction

  function automatic logic [DATA_W-1:0] insn_imm(logic [31:0] insn);
    return {{(DATA_W-IMM_W){insn[IMM_W-1]}}, insn[IMM_W-1:0]};
  endfunction

  function automatic logic op_valid(logic [31:0] insn);
    return insn[OPC_LSB +: 4] <= OP_CMP;
  endfunction

  function automatic logic cond_valid(logic [31:0] insn);
    return insn[COND_LSB +: 4] <= COND_LE;
  endfunction

  // source needs, as masks per opcode
  function automatic logic uses_ra(opcode_t op);
    return op != OP_LDI;
  endfunction

  function automatic logic uses_rb(opcode_t op);
    return op <= OP_SAR || op == OP_CMP;
  endfunction

  function automatic logic cond_true(cond_t cond, flags_t f);
    logic lt;
    logic res;
    lt = f.n ^ f.v;
    case (cond)
      COND_AL:  res = 1'b1;
      COND_EQ:  res = f.z;
      COND_NE:  res = !f.z;
      COND_LT:  res = lt;
      COND_GE:  res = !lt;
      COND_LTU: res = !f.c;
      COND_GEU: res = f.c;
      COND_GT:  res = !f.z && !lt;
      COND_LE:  res = f.z || lt;
      default:  res = 1'b0;
    endcase
    return res;
  endfunction

endpackage

//--- sched/issue_queue.sv
`timescale 1ns/1ps

module issue_queue import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               insert,
  input  logic [31:0]                        insn,
  input  logic [DATA_W-1:0]                  rf_a_data,
  input  logic [DATA_W-1:0]                  rf_b_data,
  input  logic [NUM_REGS-1:0]                pending,
  input  flags_t                             flags,
  input  logic                               wb_valid,
  input  logic [REG_W-1:0]                   wb_rd,
  input  logic [DATA_W-1:0]                  wb_data,
  input  logic                               wb_write,
  output logic                               queue_full,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_count,
  output logic                               issue_valid,
  output opcode_t                            issue_op,
  output cond_t                              issue_cond,
  output logic [REG_W-1:0]                   issue_rd,
  output logic [DATA_W-1:0]                  issue_a,
  output logic [DATA_W-1:0]                  issue_b,
  output flags_t                             issue_flags
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH+1);
  localparam int IDX_W = QUEUE_DEPTH > 1 ? $clog2(QUEUE_DEPTH) : 1;

  logic [QUEUE_DEPTH-1:0] valid;
  logic [QUEUE_DEPTH-1:0] a_rdy;
  logic [QUEUE_DEPTH-1:0] b_rdy;
  logic [QUEUE_DEPTH-1:0] ready_vec;
  opcode_t                op_q    [QUEUE_DEPTH];
  cond_t                  cond_q  [QUEUE_DEPTH];
  logic [REG_W-1:0]       rd_q    [QUEUE_DEPTH];
  logic [REG_W-1:0]       a_tag   [QUEUE_DEPTH];
  logic [REG_W-1:0]       b_tag   [QUEUE_DEPTH];
  logic [DATA_W-1:0]      a_val   [QUEUE_DEPTH];
  logic [DATA_W-1:0]      b_val   [QUEUE_DEPTH];
  flags_t                 flags_q [QUEUE_DEPTH];

  logic [IDX_W-1:0]  sel;
  logic [IDX_W-1:0]  alloc;
  opcode_t           in_op;
  logic [REG_W-1:0]  in_ra;
  logic [REG_W-1:0]  in_rb;
  logic              wb_hit;
  logic              a_hit;
  logic              b_hit;
  logic              a_rdy_in;
  logic              b_rdy_in;
  logic [DATA_W-1:0] a_val_in;
  logic [DATA_W-1:0] b_val_in;

  function automatic logic [IDX_W-1:0] lowest_set(logic [QUEUE_DEPTH-1:0] v);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = QUEUE_DEPTH - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  assign ready_vec   = valid & a_rdy & b_rdy;
  assign issue_valid = |ready_vec;
  assign sel         = lowest_set(ready_vec);
  assign alloc       = lowest_set(~valid);
  assign queue_full  = &valid;

  always_comb begin
    queue_count = '0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      queue_count = queue_count + CNT_W'(valid[i]);
    end
  end

  assign issue_op    = op_q[sel];
  assign issue_cond  = cond_q[sel];
  assign issue_rd    = rd_q[sel];
  assign issue_a     = a_val[sel];
  assign issue_b     = b_val[sel];
  assign issue_flags = flags_q[sel];

  // source readiness at insert, with bypass from this cycle's broadcast
  assign in_op  = insn_opcode(insn);
  assign in_ra  = insn_ra(insn);
  assign in_rb  = insn_rb(insn);
  assign wb_hit = wb_valid && wb_write;
  assign a_hit  = wb_hit && wb_rd == in_ra;
  assign b_hit  = wb_hit && wb_rd == in_rb;

  assign a_rdy_in = !uses_ra(in_op) || !pending[in_ra] || a_hit;
  assign a_val_in = a_hit ? wb_data : rf_a_data;

  // addi and ldi carry the immediate in operand b
  assign b_rdy_in = !uses_rb(in_op) || !pending[in_rb] || b_hit;
  assign b_val_in = !uses_rb(in_op) ? insn_imm(insn) : (b_hit ? wb_data : rf_b_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      a_rdy <= '0;
      b_rdy <= '0;
    end else begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        if (wb_hit && !a_rdy[i] && a_tag[i] == wb_rd) begin
          a_rdy[i] <= 1'b1;
        end
        if (wb_hit && !b_rdy[i] && b_tag[i] == wb_rd) begin
          b_rdy[i] <= 1'b1;
        end
      end
      if (issue_valid) begin
        valid[sel] <= 1'b0;
      end
      if (insert) begin
        valid[alloc] <= 1'b1;
        a_rdy[alloc] <= a_rdy_in;
        b_rdy[alloc] <= b_rdy_in;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (wb_hit && !a_rdy[i] && a_tag[i] == wb_rd) begin
        a_val[i] <= wb_data;
      end
      if (wb_hit && !b_rdy[i] && b_tag[i] == wb_rd) begin
        b_val[i] <= wb_data;
      end
    end
    if (insert) begin
      op_q[alloc]    <= in_op;
      cond_q[alloc]  <= insn_cond(insn);
      rd_q[alloc]    <= insn_rd(insn);
      a_tag[alloc]   <= in_ra;
      b_tag[alloc]   <= in_rb;
      a_val[alloc]   <= a_val_in;
      b_val[alloc]   <= b_val_in;
      flags_q[alloc] <= flags;
    end
  end

endmodule

//--- src/apb_front.sv
`timescale 1ns/1ps

module apb_front import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [11:0]                        paddr,
  input  logic [31:0]                        pwdata,
  input  logic                               queue_full,
  input  logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_count,
  input  logic [NUM_REGS-1:0]                pending,
  input  logic                               flags_pending,
  input  flags_t                             flags,
  input  logic [DATA_W-1:0]                  rf_rd_data,
  output logic                               pready,
  output logic [31:0]                        prdata,
  output logic                               pslverr,
  output logic                               insert,
  output logic [31:0]                        insn,
  output logic [REG_W-1:0]                   rf_rd_addr
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH+1);

  logic        access;
  logic        is_insn;
  logic        is_reg;
  logic        is_flags;
  logic        is_status;
  logic        is_cmp;
  logic        bad;
  logic        wr_stall;
  logic        rd_stall;
  logic        go;
  logic [31:0] rd_mux;

  // one completion per transfer, pready itself ends the access
  assign access = psel && penable && !pready;

  assign rf_rd_addr = paddr[2 +: REG_W];

  assign is_insn   = paddr == ADDR_INSN;
  assign is_reg    = paddr[11:6] == ADDR_REG_BASE[11:6] && paddr[1:0] == 2'b00;
  assign is_flags  = paddr == ADDR_FLAGS;
  assign is_status = paddr == ADDR_STATUS;
  assign is_cmp    = insn_opcode(pwdata) == OP_CMP;

  always_comb begin
    if (pwrite) begin
      bad = !(is_insn && op_valid(pwdata) && cond_valid(pwdata));
    end else begin
      bad = !(is_reg || is_flags || is_status);
    end
  end

  // back-pressure on insert
  assign wr_stall = queue_full
                 || (!is_cmp && pending[insn_rd(pwdata)])
                 || (flags_pending && (is_cmp || insn_cond(pwdata) != COND_AL));

  assign rd_stall = (is_reg && pending[rf_rd_addr]) || (is_flags && flags_pending);

  assign go = access && (bad || (pwrite ? !wr_stall : !rd_stall));

  always_comb begin
    rd_mux = '0;
    if (is_reg) begin
      rd_mux = rf_rd_data;
    end else if (is_flags) begin
      rd_mux = {28'b0, flags};
    end else if (is_status) begin
      rd_mux = {{(32-CNT_W){1'b0}}, queue_count};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      insert  <= 1'b0;
    end else begin
      pready  <= go;
      pslverr <= go && bad;
      insert  <= go && !bad && pwrite;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      prdata <= bad ? 32'b0 : rd_mux;
      insn   <= pwdata;
    end
  end

endmodule

//--- src/issue_slice_top.sv
`timescale 1ns/1ps

module issue_slice_top import issue_pkg::*; #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic        pready,
  output logic [31:0] prdata,
  output logic        pslverr
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH+1);

  logic                insert;
  logic [31:0]         insn;
  logic [REG_W-1:0]    rf_rd_addr;
  logic [DATA_W-1:0]   rf_a_data;
  logic [DATA_W-1:0]   rf_b_data;
  logic [DATA_W-1:0]   rf_rd_data;
  logic [NUM_REGS-1:0] pending;
  flags_t              flags;
  logic                flags_pending;
  logic                queue_full;
  logic [CNT_W-1:0]    queue_count;

  logic                issue_valid;
  opcode_t             issue_op;
  cond_t               issue_cond;
  logic [REG_W-1:0]    issue_rd;
  logic [DATA_W-1:0]   issue_a;
  logic [DATA_W-1:0]   issue_b;
  flags_t              issue_flags;

  logic                wb_valid;
  logic [REG_W-1:0]    wb_rd;
  logic [DATA_W-1:0]   wb_data;
  logic                wb_write;
  logic                wb_flags_valid;
  flags_t              wb_flags;

  apb_front #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_apb_front (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .queue_full, .queue_count, .pending, .flags_pending, .flags, .rf_rd_data,
    .pready, .prdata, .pslverr, .insert, .insn, .rf_rd_addr
  );

  issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_issue_queue (
    .clk, .rst, .insert, .insn, .rf_a_data, .rf_b_data, .pending, .flags,
    .wb_valid, .wb_rd, .wb_data, .wb_write,
    .queue_full, .queue_count, .issue_valid, .issue_op, .issue_cond,
    .issue_rd, .issue_a, .issue_b, .issue_flags
  );

  reg_file u_reg_file (
    .clk, .rst, .insert, .insn, .rf_rd_addr,
    .wb_valid, .wb_rd, .wb_data, .wb_write, .wb_flags_valid, .wb_flags,
    .rf_a_data, .rf_b_data, .rf_rd_data, .pending, .flags, .flags_pending
  );

  exec_alu u_exec_alu (
    .clk, .rst, .issue_valid, .issue_op, .issue_cond, .issue_rd,
    .issue_a, .issue_b, .issue_flags,
    .wb_valid, .wb_rd, .wb_data, .wb_write, .wb_flags_valid, .wb_flags
  );

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file import issue_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                insert,
  input  logic [31:0]         insn,
  input  logic [REG_W-1:0]    rf_rd_addr,
  input  logic                wb_valid,
  input  logic [REG_W-1:0]    wb_rd,
  input  logic [DATA_W-1:0]   wb_data,
  input  logic                wb_write,
  input  logic                wb_flags_valid,
  input  flags_t              wb_flags,
  output logic [DATA_W-1:0]   rf_a_data,
  output logic [DATA_W-1:0]   rf_b_data,
  output logic [DATA_W-1:0]   rf_rd_data,
  output logic [NUM_REGS-1:0] pending,
  output flags_t              flags,
  output logic                flags_pending
);

  logic [NUM_REGS-1:0][DATA_W-1:0] regs;
  logic                            ins_live;
  logic                            ins_cmp;

  assign rf_a_data  = regs[insn_ra(insn)];
  assign rf_b_data  = regs[insn_rb(insn)];
  assign rf_rd_data = regs[rf_rd_addr];

  // flags are settled at insert for any conditional op, so the outcome is known here.
  // a false condition never marks its destination and never writes it back
  assign ins_live = insert && cond_true(insn_cond(insn), flags);
  assign ins_cmp  = insn_opcode(insn) == OP_CMP;

  always_ff @(posedge clk) begin
    if (rst) begin
      regs          <= '0;
      pending       <= '0;
      flags         <= '0;
      flags_pending <= 1'b0;
    end else begin
      if (wb_valid && wb_write) begin
        regs[wb_rd]    <= wb_data;
        pending[wb_rd] <= 1'b0;
      end
      if (wb_valid && wb_flags_valid) begin
        flags         <= wb_flags;
        flags_pending <= 1'b0;
      end
      // set wins over clear
      if (ins_live) begin
        if (ins_cmp) begin
          flags_pending <= 1'b1;
        end else begin
          pending[insn_rd(insn)] <= 1'b1;
        end
      end
    end
  end

endmodule

//--- vlog.f
common/issue_pkg.sv
src/apb_front.sv
sched/issue_queue.sv
alu/exec_alu.sv
src/reg_file.sv
src/issue_slice_top.sv
bench/clk_gen.sv
bench/result_check.sv
bench/tb_top.sv
